// File: bx_sequencer.sv
/*
  Bunch-crossing burst generator.
  Runs a bxclk burst with a test trigger on the first period and counts
  the chip's event toggles for the readback.
*/
`timescale 1ns/100ps

module bx_sequencer (
  input  logic                            iob_clk,
  input  logic                            arst_n,
  input  logic                            start,
  input  logic [3:0]                      half_period,
  input  logic [7:0]                      count,
  output logic                            bxclk,
  output logic                            trig,
  input  logic                            dn_event_toggle,
  input  logic                            dnn_output_0,
  input  logic                            dnn_output_1,
  output logic                            done,
  output logic [pix_test_pkg::rdbk_w-1:0] rdbk
);
  import pix_test_pkg::*;

  logic                running;
  logic                draining;    // Waits out the pin round trip
  logic                half_end;
  logic [3:0]          hp_q;
  logic [7:0]          cnt_q;
  logic [3:0]          phase;
  logic [7:0]          per_cnt;     // Full periods done
  logic [2:0]          drain_cnt;
  logic                ev_q;
  logic [ev_cnt_w-1:0] ev_cnt;
  logic [1:0]          dnn_q;

  assign half_end = running && (phase == hp_q);
  assign trig     = running && (per_cnt == '0);
  assign rdbk     = {dnn_q, ev_cnt};

  // --------------------
  // Burst FSM
  // --------------------
  always_ff @(posedge iob_clk or negedge arst_n) begin
    if (!arst_n) begin
      running   <= 1'b0;
      draining  <= 1'b0;
      bxclk     <= 1'b0;
      phase     <= '0;
      per_cnt   <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !running && !draining) begin
        running   <= (count != 8'd0);
        draining  <= (count == 8'd0);   // Empty burst just drains
        bxclk     <= (count != 8'd0);   // Each period opens on a rise
        phase     <= '0;
        per_cnt   <= '0;
        drain_cnt <= '0;
      end else if (running) begin
        phase <= phase + 1'b1;
        if (half_end) begin
          phase <= '0;
          if (bxclk) begin
            bxclk <= 1'b0;
          end else if (per_cnt == cnt_q - 8'd1) begin
            running  <= 1'b0;
            draining <= 1'b1;
          end else begin
            bxclk   <= 1'b1;
            per_cnt <= per_cnt + 1'b1;
          end
        end
      end else if (draining) begin
        drain_cnt <= drain_cnt + 1'b1;
        if (int'(drain_cnt) == bx_drain - 1) begin
          draining <= 1'b0;
          done     <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge iob_clk) begin
    if (start && !running && !draining) begin
      hp_q  <= half_period;
      cnt_q <= count;
    end
  end

  // Event counter, any toggle edge is one event
  always_ff @(posedge iob_clk or negedge arst_n) begin
    if (!arst_n) begin
      ev_q   <= 1'b0;
      ev_cnt <= '0;
      dnn_q  <= '0;
    end else begin
      ev_q <= dn_event_toggle;
      if (start) begin
        ev_cnt <= '0;
        dnn_q  <= '0;
      end else if (dn_event_toggle != ev_q) begin
        ev_cnt <= ev_cnt + 1'b1;
        dnn_q  <= {dnn_output_1, dnn_output_0};
      end
    end
  end

endmodule

// File: com_fw_to_dut.sv
/*
  Firmware to chip pin mux.
  Routes the one-hot selected slot onto registered output pins and
  hands the registered chip inputs back to that slot only.
*/
`timescale 1ns/100ps

module com_fw_to_dut (
  input  logic                            iob_clk,
  input  logic                            arst_n,
  input  logic [pix_test_pkg::fw_num-1:0] fw_dev_id_enable,
  input  pix_test_pkg::fw_out_t           fw_out [pix_test_pkg::fw_num],
  output pix_test_pkg::fw_in_t            fw_in  [pix_test_pkg::fw_num],
  output pix_test_pkg::fw_out_t           pin_out,
  input  pix_test_pkg::fw_in_t            pin_in
);
  import pix_test_pkg::*;

  logic [fw_num-1:0] slot_hit;   // Set only for a clean one-hot enable
  fw_out_t           out_mux;
  fw_in_t            in_iob;     // Input IOB flops

  // --------------------
  // Slot decode
  // --------------------
  always_comb begin
    for (int i = 0; i < fw_num; i++) begin
      slot_hit[i] = (fw_dev_id_enable == (fw_num'(1) << i));
    end
  end

  // Zero enable or several bits set leaves the pins quiet
  always_comb begin
    out_mux = '0;
    for (int i = 0; i < fw_num; i++) begin
      if (slot_hit[i]) begin
        out_mux = fw_out[i];
      end
    end
  end

  // --------------------
  // Output IOB flops
  // --------------------
  // Reset value keeps reset_not low, chip stays in reset
  always_ff @(posedge iob_clk or negedge arst_n) begin
    if (!arst_n) begin
      pin_out <= '0;
    end else begin
      pin_out <= out_mux;
    end
  end

  // --------------------
  // Input IOB flops
  // --------------------
  always_ff @(posedge iob_clk) begin
    in_iob <= pin_in;
  end

  // Fan back to the owner, zero everywhere else
  always_comb begin
    for (int i = 0; i < fw_num; i++) begin
      fw_in[i] = slot_hit[i] ? in_iob : '0;
    end
  end

endmodule

// File: fw_ctrl.sv
/*
  Test firmware control.
  Decodes host commands, owns the slot enable, starts one engine at a
  time and reports its readback with a response strobe.
*/
`timescale 1ns/100ps

module fw_ctrl (
  input  logic                                iob_clk,
  input  logic                                arst_n,
  input  logic                                cmd_valid,
  input  pix_test_pkg::cmd_word_u             cmd_word,
  output logic [pix_test_pkg::fw_num-1:0]     fw_dev_id_enable,
  output logic                                config_start,
  output logic                                scan_start,
  output logic                                bx_start,
  output logic [pix_test_pkg::config_len-1:0] config_data,
  output logic [pix_test_pkg::scan_len-1:0]   scan_data,
  output logic [3:0]                          bx_half_period,
  output logic [7:0]                          bx_count,
  input  logic                                config_done,
  input  logic                                scan_done,
  input  logic                                bx_done,
  input  logic [pix_test_pkg::config_len-1:0] config_rdbk,
  input  logic [pix_test_pkg::scan_len-1:0]   scan_rdbk,
  input  logic [pix_test_pkg::rdbk_w-1:0]     bx_rdbk,
  output logic                                busy,
  output logic                                rsp_valid,
  output logic [pix_test_pkg::rdbk_w-1:0]     rsp_data
);
  import pix_test_pkg::*;

  logic              run;        // FSM state, idle when low
  logic [3:0]        opcode;
  logic              accept;
  logic              eng_done;   // Done of the engine on the pins
  logic [rdbk_w-1:0] rdbk_sel;

  assign opcode = cmd_word.shift.opcode;   // Same nibble in both views
  assign accept = cmd_valid && !run;       // Commands while busy are dropped
  assign busy   = run;

  // Readback source follows the selected slot
  always_comb begin
    eng_done = 1'b0;
    rdbk_sel = '0;
    if (fw_dev_id_enable[slot_config]) begin
      eng_done = config_done;
      rdbk_sel = config_rdbk;
    end else if (fw_dev_id_enable[slot_scan]) begin
      eng_done = scan_done;
      rdbk_sel = {{(rdbk_w - scan_len){1'b0}}, scan_rdbk};
    end else if (fw_dev_id_enable[slot_bx]) begin
      eng_done = bx_done;
      rdbk_sel = bx_rdbk;
    end
  end

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge iob_clk or negedge arst_n) begin
    if (!arst_n) begin
      run              <= 1'b0;
      fw_dev_id_enable <= '0;
      config_start     <= 1'b0;
      scan_start       <= 1'b0;
      bx_start         <= 1'b0;
      rsp_valid        <= 1'b0;
    end else begin
      config_start <= 1'b0;
      scan_start   <= 1'b0;
      bx_start     <= 1'b0;
      rsp_valid    <= 1'b0;
      if (accept) begin
        case (opcode)
          op_config: begin
            fw_dev_id_enable <= fw_num'(1) << slot_config;
            config_start     <= 1'b1;
            run              <= 1'b1;
          end
          op_scan: begin
            fw_dev_id_enable <= fw_num'(1) << slot_scan;
            scan_start       <= 1'b1;
            run              <= 1'b1;
          end
          op_bx: begin
            fw_dev_id_enable <= fw_num'(1) << slot_bx;
            bx_start         <= 1'b1;
            run              <= 1'b1;
          end
          op_ext: fw_dev_id_enable <= fw_num'(1) << slot_ext;  // Pins only
          default: ;
        endcase
      end else if (run && eng_done) begin
        run       <= 1'b0;
        rsp_valid <= 1'b1;
      end
    end
  end

  // Operands and response payload
  always_ff @(posedge iob_clk) begin
    if (accept) begin
      config_data    <= cmd_word.shift.data;
      scan_data      <= cmd_word.shift.data[scan_len-1:0];
      bx_half_period <= cmd_word.bx.half_period;
      bx_count       <= cmd_word.bx.bx_count;
    end
    if (run && eng_done) begin
      rsp_data <= rdbk_sel;
    end
  end

endmodule

// File: pix_test_checker.sv
/*
  Bound assertions for the test firmware top level.
  Slot enable encoding, quiet pins on a zero enable, response strobe.
*/
`timescale 1ns/100ps

module pix_test_checker (
  input logic                            iob_clk,
  input logic                            arst_n,
  input logic [pix_test_pkg::fw_num-1:0] fw_dev_id_enable,
  input pix_test_pkg::fw_out_t           pin_out,
  input logic                            busy,
  input logic                            rsp_valid
);

  // One slot at most on the pins
  enable_onehot: assert property (
    @(posedge iob_clk) disable iff (!arst_n) $onehot0(fw_dev_id_enable)
  ) else $error("slot enable has more than one bit set");

  // No slot selected means all pins low, reset_not included
  pins_quiet: assert property (
    @(posedge iob_clk) disable iff (!arst_n)
    (fw_dev_id_enable == '0) |=> (pin_out == '0)
  ) else $error("pins active one cycle after a zero slot enable");

  rsp_after_busy: assert property (
    @(posedge iob_clk) disable iff (!arst_n) rsp_valid |-> $past(busy)
  ) else $error("response strobe without busy in the cycle before");

endmodule

bind pix_test_top pix_test_checker u_checker (
  .iob_clk, .arst_n, .fw_dev_id_enable, .pin_out, .busy, .rsp_valid
);

// File: pix_test_pkg.sv
/*
  Pixel readout ASIC test firmware.
  Slot count, opcodes, pin structs and the host command word.
*/
package pix_test_pkg;

  // --------------------
  // Sizes and timing
  // --------------------
  localparam int fw_num     = 4;    // Firmware slots on the pin mux
  localparam int config_len = 12;   // Chip configuration register
  localparam int scan_len   = 8;    // Scan chain
  localparam int bit_cycles = 4;    // iob_clk cycles per serial bit
  localparam int bx_drain   = 4;    // Idle cycles after a burst, covers IOB latency
  localparam int ev_cnt_w   = 10;   // Event counter in the burst readback
  localparam int rdbk_w     = 12;   // Response width

  // Host opcodes, top nibble of the command
  localparam logic [3:0] op_config = 4'd1;
  localparam logic [3:0] op_scan   = 4'd2;
  localparam logic [3:0] op_bx     = 4'd3;
  localparam logic [3:0] op_ext    = 4'd4;

  // Slot index per opcode
  localparam int slot_config = 0;
  localparam int slot_scan   = 1;
  localparam int slot_bx     = 2;
  localparam int slot_ext    = 3;

  // --------------------
  // Pin bundles
  // --------------------
  typedef struct packed {
    logic super_pixel_sel;
    logic config_clk;
    logic reset_not;          // Low holds the chip in reset
    logic config_in;
    logic config_load;
    logic bxclk_ana;
    logic bxclk;
    logic vin_test_trig_out;
    logic scan_in;
    logic scan_load;
  } fw_out_t;

  typedef struct packed {
    logic config_out;
    logic scan_out;
    logic dnn_output_0;
    logic dnn_output_1;
    logic dn_event_toggle;
  } fw_in_t;

  // Command views, selected by the opcode
  typedef struct packed {
    logic [3:0]  opcode;
    logic [11:0] data;        // Scan takes the low byte
  } shift_cmd_t;

  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] half_period;
    logic [7:0] bx_count;
  } bx_cmd_t;

  typedef union packed {
    shift_cmd_t shift;
    bx_cmd_t    bx;
  } cmd_word_u;

endpackage

// File: pix_test_top.sv
/*
  Pixel ASIC test firmware top level.
  Control block, config and scan shifters, burst engine, external slot
  and the pin mux.
*/
`timescale 1ns/100ps

module pix_test_top (
  input  logic                            iob_clk,
  input  logic                            arst_n,
  input  logic                            cmd_valid,
  input  pix_test_pkg::cmd_word_u         cmd_word,
  output logic                            busy,
  output logic                            rsp_valid,
  output logic [pix_test_pkg::rdbk_w-1:0] rsp_data,
  input  pix_test_pkg::fw_out_t           ext_fw_out,
  output pix_test_pkg::fw_in_t            ext_fw_in,
  output pix_test_pkg::fw_out_t           pin_out,
  input  pix_test_pkg::fw_in_t            pin_in
);
  import pix_test_pkg::*;

  logic [fw_num-1:0]     fw_dev_id_enable;
  logic                  config_start;
  logic                  scan_start;
  logic                  bx_start;
  logic                  config_done;
  logic                  scan_done;
  logic                  bx_done;
  logic [config_len-1:0] config_data;
  logic [config_len-1:0] config_rdbk;
  logic [scan_len-1:0]   scan_data;
  logic [scan_len-1:0]   scan_rdbk;
  logic [3:0]            bx_half_period;
  logic [7:0]            bx_count;
  logic [rdbk_w-1:0]     bx_rdbk;
  logic                  cfg_clk;
  logic                  cfg_in;
  logic                  cfg_load;
  logic                  scn_clk;
  logic                  scn_in;
  logic                  scn_load;
  logic                  bx_clk;
  logic                  bx_trig;
  fw_out_t               slot_out [fw_num];
  fw_in_t                slot_in  [fw_num];

  // --------------------
  // Slot pin mapping
  // --------------------
  always_comb begin
    slot_out[slot_config]             = '0;
    slot_out[slot_config].reset_not   = 1'b1;   // Chip out of reset while selected
    slot_out[slot_config].config_clk  = cfg_clk;
    slot_out[slot_config].config_in   = cfg_in;
    slot_out[slot_config].config_load = cfg_load;
    // Scan shares config_clk, chip held in reset so config stays put
    slot_out[slot_scan]               = '0;
    slot_out[slot_scan].config_clk    = scn_clk;
    slot_out[slot_scan].scan_in       = scn_in;
    slot_out[slot_scan].scan_load     = scn_load;
    slot_out[slot_bx]                   = '0;
    slot_out[slot_bx].reset_not         = 1'b1;
    slot_out[slot_bx].bxclk             = bx_clk;
    slot_out[slot_bx].bxclk_ana         = bx_clk;  // Digital copy
    slot_out[slot_bx].vin_test_trig_out = bx_trig;
    slot_out[slot_ext]                  = ext_fw_out;
  end

  assign ext_fw_in = slot_in[slot_ext];

  fw_ctrl u_ctrl (
    .iob_clk, .arst_n, .cmd_valid, .cmd_word, .fw_dev_id_enable,
    .config_start, .scan_start, .bx_start,
    .config_data, .scan_data, .bx_half_period, .bx_count,
    .config_done, .scan_done, .bx_done,
    .config_rdbk, .scan_rdbk, .bx_rdbk,
    .busy, .rsp_valid, .rsp_data
  );

  serial_port #(.len(config_len)) u_config (
    .iob_clk, .arst_n, .start(config_start), .data(config_data),
    .ser_clk(cfg_clk), .ser_in(cfg_in), .ser_load(cfg_load),
    .ser_out(slot_in[slot_config].config_out),
    .done(config_done), .rdbk(config_rdbk)
  );

  serial_port #(.len(scan_len)) u_scan (
    .iob_clk, .arst_n, .start(scan_start), .data(scan_data),
    .ser_clk(scn_clk), .ser_in(scn_in), .ser_load(scn_load),
    .ser_out(slot_in[slot_scan].scan_out),
    .done(scan_done), .rdbk(scan_rdbk)
  );

  bx_sequencer u_bx (
    .iob_clk, .arst_n, .start(bx_start),
    .half_period(bx_half_period), .count(bx_count),
    .bxclk(bx_clk), .trig(bx_trig),
    .dn_event_toggle(slot_in[slot_bx].dn_event_toggle),
    .dnn_output_0(slot_in[slot_bx].dnn_output_0),
    .dnn_output_1(slot_in[slot_bx].dnn_output_1),
    .done(bx_done), .rdbk(bx_rdbk)
  );

  com_fw_to_dut u_pins (
    .iob_clk, .arst_n, .fw_dev_id_enable,
    .fw_out(slot_out), .fw_in(slot_in),
    .pin_out, .pin_in
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pixel test firmware testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing --assert -j 0 --top-module tb_pix_test \
  -f verilog.f --Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
  exit 1
fi
exit 0

// File: serial_port.sv
/*
  Bit-serial shift engine.
  Shifts a word out MSB first with its own clock, captures the return
  line into a readback word, then pulses the load line.
*/
`timescale 1ns/100ps

module serial_port #(
  parameter int len = 12
) (
  input  logic           iob_clk,
  input  logic           arst_n,
  input  logic           start,
  input  logic [len-1:0] data,
  output logic           ser_clk,
  output logic           ser_in,
  output logic           ser_load,
  input  logic           ser_out,
  output logic           done,
  output logic [len-1:0] rdbk
);
  import pix_test_pkg::*;

  logic                          shifting;    // Bits in flight
  logic                          loading;     // Load strobe window
  logic                          idle;
  logic                          last_phase;  // Clock low, return line sampled
  logic [$clog2(bit_cycles)-1:0] phase;
  logic [$clog2(len)-1:0]        bit_cnt;
  logic [len-1:0]                sr;

  assign idle       = !shifting && !loading;
  assign last_phase = (int'(phase) == bit_cycles - 1);

  // Bit shape: data set, clock high for the middle phases, clock low
  assign ser_clk  = shifting && (phase != '0) && !last_phase;
  assign ser_in   = shifting && sr[len-1];
  assign ser_load = loading;

  // --------------------
  // Bit sequencer
  // --------------------
  always_ff @(posedge iob_clk or negedge arst_n) begin
    if (!arst_n) begin
      shifting <= 1'b0;
      loading  <= 1'b0;
      phase    <= '0;
      bit_cnt  <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && idle) begin
        shifting <= 1'b1;
        phase    <= '0;
        bit_cnt  <= '0;
      end else if (!idle) begin
        phase <= phase + 1'b1;
        if (last_phase) begin
          phase <= '0;
          if (loading) begin
            loading <= 1'b0;
            done    <= 1'b1;
          end else if (int'(bit_cnt) == len - 1) begin
            shifting <= 1'b0;   // Last bit out, load follows
            loading  <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Shift registers, fully rewritten on every run
  always_ff @(posedge iob_clk) begin
    if (start && idle) begin
      sr <= data;
    end else if (shifting && last_phase) begin
      sr   <= {sr[len-2:0], 1'b0};
      rdbk <= {rdbk[len-2:0], ser_out};
    end
  end

endmodule

// File: tb_pix_test.sv
/*
  Testbench for the pixel ASIC test firmware.
  Random host commands against a chip pin model and a reference model.
*/
`timescale 1ns/100ps

module tb_pix_test;
  import pix_test_pkg::*;

  localparam int n_cmds     = 40;
  localparam int cmd_cycles = 124;   // Longest burst, 15 periods of 8 plus drain
  localparam int cmd_slack  = 20;    // Issue, response and ext pin steps
  localparam int max_cycles = n_cmds * (cmd_cycles + cmd_slack) + 100;
  localparam int ext_steps  = 4;

  logic              iob_clk;
  logic              arst_n;
  logic              cmd_valid;
  cmd_word_u         cmd_word;
  logic              busy;
  logic              rsp_valid;
  logic [rdbk_w-1:0] rsp_data;
  fw_out_t           ext_fw_out;
  fw_in_t            ext_fw_in;
  fw_out_t           pin_out;
  fw_in_t            pin_in;
  fw_in_t            pin_noise;     // Extra pin activity for the ext slot

  // --------------------
  // Chip and reference state
  // --------------------
  fw_out_t               prev_pin  = '0;
  fw_in_t                chip_in   = '0;
  logic [config_len-1:0] chip_cfg  = '0;
  logic [scan_len-1:0]   chip_scan = '0;
  logic [1:0]            bx_idx    = '0;
  int                    bx_rises  = 0;   // All bxclk rises seen so far
  int                    trig_rise = 0;   // Number of the last rise with trigger
  logic [config_len-1:0] ref_cfg   = '0;
  logic [scan_len-1:0]   ref_scan  = '0;
  int                    seed      = 58846;
  int                    cycles    = 0;

  pix_test_top dut (
    .iob_clk, .arst_n, .cmd_valid, .cmd_word, .busy, .rsp_valid, .rsp_data,
    .ext_fw_out, .ext_fw_in, .pin_out, .pin_in
  );

  initial begin
    iob_clk = 1'b0;
    forever #5 iob_clk = ~iob_clk;
  end

  always @(posedge iob_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // Chip model. config_out and scan_out show the bit shifted out at the last rise,
  // scan shifts only while the chip is held in reset
  always @(pin_out) begin
    if (pin_out.config_clk && !prev_pin.config_clk) begin
      if (pin_out.reset_not) begin
        chip_in.config_out = chip_cfg[config_len-1];
        chip_cfg = {chip_cfg[config_len-2:0], pin_out.config_in};
      end else begin
        chip_in.scan_out = chip_scan[scan_len-1];
        chip_scan = {chip_scan[scan_len-2:0], pin_out.scan_in};
      end
    end
    if (pin_out.bxclk && !prev_pin.bxclk) begin
      bx_rises = bx_rises + 1;
      if (pin_out.vin_test_trig_out) begin
        bx_idx    = 2'd0;   // Trigger marks bx 0
        trig_rise = bx_rises;
      end else begin
        bx_idx = bx_idx + 2'd1;
      end
      chip_in.dn_event_toggle = !chip_in.dn_event_toggle;
      chip_in.dnn_output_0    = bx_idx[0];
      chip_in.dnn_output_1    = bx_idx[1];
    end
    prev_pin = pin_out;
  end

  assign pin_in = chip_in ^ pin_noise;

  // --------------------
  // Tasks
  // --------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic send_command(input cmd_word_u w);
    @(posedge iob_clk);
    cmd_valid <= 1'b1;
    cmd_word  <= w;
    @(posedge iob_clk);
    cmd_valid <= 1'b0;
    @(negedge iob_clk);
  endtask

  task automatic wait_response();
    while (!rsp_valid) @(negedge iob_clk);
  endtask

  task automatic run_shift(input logic [3:0] op, input logic [11:0] data);
    cmd_word_u w;
    w = '0;
    w.shift.opcode = op;
    w.shift.data   = data;
    send_command(w);
    check_value("busy", 32'(busy), 32'd1);
    wait_response();
    check_value("busy", 32'(busy), 32'd0);
    if (op == op_config) begin
      check_value("fw_dev_id_enable", 32'(dut.fw_dev_id_enable), 32'd1 << slot_config);
      check_value("rsp_data", 32'(rsp_data), 32'(ref_cfg));
      ref_cfg = data;
      check_value("chip config register", 32'(chip_cfg), 32'(ref_cfg));
    end else begin
      check_value("fw_dev_id_enable", 32'(dut.fw_dev_id_enable), 32'd1 << slot_scan);
      check_value("rsp_data", 32'(rsp_data), 32'(ref_scan));
      ref_scan = data[scan_len-1:0];
      check_value("chip scan register", 32'(chip_scan), 32'(ref_scan));
    end
  endtask

  task automatic run_burst(input logic [3:0] hp, input logic [7:0] cnt);
    cmd_word_u  w;
    logic [7:0] last_idx;
    int         rises_before;
    w.bx.opcode      = op_bx;
    w.bx.half_period = hp;
    w.bx.bx_count    = cnt;
    last_idx         = cnt - 8'd1;
    rises_before     = bx_rises;
    send_command(w);
    check_value("busy", 32'(busy), 32'd1);
    wait_response();
    check_value("fw_dev_id_enable", 32'(dut.fw_dev_id_enable), 32'd1 << slot_bx);
    check_value("rsp_data", 32'(rsp_data), 32'({last_idx[1:0], 2'b00, cnt}));
    check_value("bxclk rises", bx_rises - rises_before, 32'(cnt));
    check_value("trigger rise", trig_rise, rises_before + 1);
  endtask

  task automatic run_ext();
    cmd_word_u   w;
    logic [31:0] r;
    fw_out_t     v;
    fw_in_t      n;
    w = '0;
    w.shift.opcode = op_ext;
    send_command(w);
    check_value("busy", 32'(busy), 32'd0);
    check_value("fw_dev_id_enable", 32'(dut.fw_dev_id_enable), 32'd1 << slot_ext);
    repeat (ext_steps) begin
      @(posedge iob_clk);
      r            = $random(seed);
      v            = r[9:0];
      n            = r[20:16];
      v.config_clk = 1'b0;   // Chip registers stay put
      v.bxclk      = 1'b0;
      ext_fw_out <= v;
      pin_noise  <= n;
      @(posedge iob_clk);
      @(negedge iob_clk);
      check_value("pin_out", 32'(pin_out), 32'(v));
      check_value("ext_fw_in", 32'(ext_fw_in), 32'(chip_in ^ n));
      for (int k = 0; k < slot_ext; k++) begin
        check_value("slot_in", 32'(dut.slot_in[k]), 32'd0);
      end
    end
    @(posedge iob_clk);
    ext_fw_out <= '0;
    pin_noise  <= '0;
    repeat (2) @(posedge iob_clk);
  endtask

  task automatic run_ignored(input logic [3:0] op, input logic [11:0] data);
    cmd_word_u  w;
    logic [3:0] en_before;
    en_before      = dut.fw_dev_id_enable;
    w.shift.opcode = op;
    w.shift.data   = data;
    send_command(w);
    repeat (4) begin
      check_value("busy", 32'(busy), 32'd0);
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);
      check_value("fw_dev_id_enable", 32'(dut.fw_dev_id_enable), 32'(en_before));
      @(negedge iob_clk);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    logic [31:0] r;
    logic [7:0]  cnt;
    logic [3:0]  bad_op;
    int          sel;
    arst_n     = 1'b0;
    cmd_valid  = 1'b0;
    cmd_word   = '0;
    ext_fw_out = '0;
    pin_noise  = '0;
    repeat (7) @(posedge iob_clk);
    @(negedge iob_clk);
    check_value("pin_out", 32'(pin_out), 32'd0);
    @(posedge iob_clk);
    arst_n <= 1'b1;
    @(negedge iob_clk);
    check_value("pin_out", 32'(pin_out), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    check_value("fw_dev_id_enable", 32'(dut.fw_dev_id_enable), 32'd0);

    for (int i = 0; i < n_cmds; i++) begin
      r      = $random(seed);
      sel    = int'(r[7:0]) % 10;
      cnt    = (r[25:22] == 4'd0) ? 8'd15 : {4'h0, r[25:22]};
      bad_op = (r[29:26] >= 4'd1 && r[29:26] <= 4'd4) ? 4'd0 : r[29:26];
      if (sel < 3) begin
        run_shift(op_config, r[19:8]);
      end else if (sel < 5) begin
        run_shift(op_scan, r[19:8]);
      end else if (sel < 8) begin
        run_burst({2'b00, r[21:20]}, cnt);
      end else if (sel < 9) begin
        run_ext();
      end else begin
        run_ignored(bad_op, r[19:8]);
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verilog.f
pix_test_pkg.sv
com_fw_to_dut.sv
fw_ctrl.sv
serial_port.sv
bx_sequencer.sv
pix_test_top.sv
pix_test_checker.sv
tb_pix_test.sv
